/* hw/fetch_pkg.sv */
/*
 * Shared types for the instruction fetch subsystem
 * Word and opcode types, branch opcode constant
 * Instruction bus request and response structs
 * Redirect, prediction and hazard control structs
 * Fetch to execute pipeline register struct
 */

package fetch_pkg;

    // Instruction or address word
    typedef logic [31:0] word_t;

    // Major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // Conditional branches (BEQ, BNE, BLT, BGE, BLTU, BGEU)
    localparam opcode_t OPCODE_BRANCH = 7'b110_0011;

    // Read request, address held while busy
    typedef struct packed {
        logic  ren;
        word_t addr;
    } ibus_req_t;

    // Read response, rdata and error valid only when busy is low
    typedef struct packed {
        word_t rdata;
        logic  busy;
        logic  error;
    } ibus_rsp_t;

    // Resolved branch or jump from execute, valid is a one cycle pulse
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // Fetch to execute register
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  prediction;
        logic  mal_insn;
        logic  fault_insn;
        word_t badaddr;
    } fetch_ex_t;

    // Static predictor result
    typedef struct packed {
        logic  taken;
        word_t target;
    } predict_t;

    // Hazard unit to fetch stage
    typedef struct packed {
        logic  pc_en;
        logic  if_ex_stall;
        logic  if_ex_flush;
        logic  iren;
        logic  use_redirect;
        word_t redirect_target;
    } hazard_ctrl_t;

endpackage

/* hw/branch_predictor.sv */
/*
 * Static backward taken branch predictor
 * B-type immediate decode and target adder
 */

`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  word_t    pc,
    input  word_t    instr,
    input  logic     instr_valid,
    output predict_t predict
);

    opcode_t opcode;
    word_t   imm_b;
    logic    is_branch;

    assign opcode = instr[6:0];

    // imm[12|10:5] in [31:25], imm[4:1|11] in [11:7], bit 0 always zero
    assign imm_b = {
        {19{instr[31]}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    assign is_branch = instr_valid && (opcode == OPCODE_BRANCH);

    // Backward branches are usually loop ends, so guess taken
    assign predict.taken  = is_branch && imm_b[31];
    assign predict.target = pc + imm_b;

    // Holds only as long as fetch gates prediction on misaligned PCs
    always_comb begin
        if (predict.taken) begin
            a_target_aligned: assert final (predict.target[0] == 1'b0)
                else $error("predicted branch target is not halfword aligned");
        end
    end

endmodule

/* hw/hazard_unit.sv */
/*
 * Fetch hazard controller
 * Redirect capture and drain of an outstanding read
 * PC enable, fetch to execute stall and flush, read enable
 */

`timescale 1ns/1ps

module hazard_unit import fetch_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_1000
) (
    input  logic         CLK,
    input  logic         nRST,
    input  redirect_t    redirect,
    input  logic         ex_stall,
    input  logic         ibus_busy,
    input  logic         rdata_done,
    output hazard_ctrl_t ctrl
);

    // RUN normal fetch, DRAIN wait out a read, REDIRECT wait out a stall
    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        REDIRECT
    } state_t;

    state_t state;
    state_t state_next;
    word_t  pend_target;
    logic   apply;

    // Decide when the held or incoming redirect takes effect
    always_comb begin
        state_next = state;
        apply      = 1'b0;
        case (state)
            RUN: begin
                if (redirect.valid) begin
                    if (ibus_busy) begin
                        state_next = DRAIN;
                    end else if (ex_stall) begin
                        state_next = REDIRECT;
                    end else begin
                        apply = 1'b1;
                    end
                end
            end
            DRAIN: begin
                // Data of the finished read is dropped by the flush
                if (rdata_done) begin
                    if (ex_stall) begin
                        state_next = REDIRECT;
                    end else begin
                        apply      = 1'b1;
                        state_next = RUN;
                    end
                end
            end
            REDIRECT: begin
                if (!ex_stall) begin
                    apply      = 1'b1;
                    state_next = RUN;
                end
            end
            default: begin
                state_next = RUN;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= RUN;
            pend_target <= RESET_PC;
        end else begin
            state <= state_next;
            // Latest redirect wins
            if (redirect.valid) begin
                pend_target <= redirect.target;
            end
        end
    end

    // A pulse in this cycle bypasses the capture register
    assign ctrl.redirect_target = redirect.valid ? redirect.target : pend_target;
    assign ctrl.use_redirect    = apply;
    assign ctrl.if_ex_flush     = apply;
    assign ctrl.if_ex_stall     = ex_stall;
    assign ctrl.pc_en           = apply || (state == RUN && !redirect.valid && rdata_done &&
                                            !ex_stall);
    // Old read is already finished and dropped while waiting to redirect
    assign ctrl.iren            = (state != REDIRECT);

    // An idle bus in DRAIN always means the held read has completed
    property p_drain_exit;
        @(posedge CLK) disable iff (!nRST)
        (state == DRAIN && !ibus_busy) |-> rdata_done;
    endproperty

    a_drain_exit: assert property (p_drain_exit)
        else $error("DRAIN saw an idle bus without a completed read");

endmodule

/* hw/fetch_stage.sv */
/*
 * Fetch stage of the RV32I pipeline
 * PC register and next PC selection
 * Instruction bus request and completion
 * Misaligned and bus error detection
 * Fetch to execute register with stall, flush and squash
 */

`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_1000
) (
    input  logic         CLK,
    input  logic         nRST,
    output ibus_req_t    ibus_req,
    input  ibus_rsp_t    ibus_rsp,
    input  predict_t     predict,
    input  hazard_ctrl_t ctrl,
    output word_t        pc,
    output logic         rdata_done,
    output logic         fault,
    output fetch_ex_t    fetch_ex
);

    word_t pc4;
    word_t npc;
    word_t instr;
    logic  bus_done;
    logic  mal_insn;
    logic  fault_insn;

    // Sequential successor
    assign pc4 = pc + 32'd4;

    // Redirect first, then backward branch prediction, then pc+4
    always_comb begin
        if (ctrl.use_redirect) begin
            npc = ctrl.redirect_target;
        end else if (predict.taken) begin
            npc = predict.target;
        end else begin
            npc = pc4;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (ctrl.pc_en) begin
            pc <= npc;
        end
    end

    // Low PC bits set means the fetch cannot be aligned to a word
    assign mal_insn = (pc[1:0] != 2'b00);

    // Misaligned fetches never go on the bus
    assign ibus_req.ren  = ctrl.iren && !mal_insn;
    assign ibus_req.addr = pc;

    // Read finishes in the first cycle with ren high and busy low
    assign bus_done   = ibus_req.ren && !ibus_rsp.busy;
    assign fault_insn = bus_done && ibus_rsp.error;

    // A misaligned fetch completes at once, as a faulting entry
    assign rdata_done = bus_done || (ctrl.iren && mal_insn);
    assign fault      = mal_insn || fault_insn;

    // Faulting fetches are squashed to a zero word
    assign instr = fault ? '0 : ibus_rsp.rdata;

    // Fetch to execute register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '0;
        end else if (!ctrl.if_ex_stall) begin
            if (ctrl.if_ex_flush || !rdata_done) begin
                // Flushed path or bus still busy, load a bubble
                fetch_ex <= '0;
            end else begin
                fetch_ex.valid      <= 1'b1;
                fetch_ex.instr      <= instr;
                fetch_ex.pc         <= pc;
                fetch_ex.pc4        <= pc4;
                fetch_ex.prediction <= predict.taken;
                fetch_ex.mal_insn   <= mal_insn;
                fetch_ex.fault_insn <= fault_insn;
                // Exception handler sees the faulting PC
                fetch_ex.badaddr    <= pc;
            end
        end
    end

    // Memory must see a steady request for the whole wait
    property p_addr_stable;
        @(posedge CLK) disable iff (!nRST)
        (ibus_req.ren && ibus_rsp.busy) |=> (ibus_req.ren && $stable(ibus_req.addr));
    endproperty

    a_addr_stable: assert property (p_addr_stable)
        else $error("fetch address changed while the bus was busy");

    // Stall has priority in the register and would swallow a flush
    property p_flush_no_stall;
        @(posedge CLK) disable iff (!nRST)
        ctrl.if_ex_flush |-> !ctrl.if_ex_stall;
    endproperty

    a_flush_no_stall: assert property (p_flush_no_stall)
        else $error("flush arrived together with a stall");

endmodule

/* hw/fetch_top.sv */
/*
 * Top level of the instruction fetch subsystem
 * Fetch stage, branch predictor and hazard unit
 */

`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_1000
) (
    input  logic      CLK,
    input  logic      nRST,
    output ibus_req_t ibus_req,
    input  ibus_rsp_t ibus_rsp,
    input  redirect_t redirect,
    input  logic      ex_stall,
    output fetch_ex_t fetch_ex
);

    predict_t     predict;
    hazard_ctrl_t ctrl;
    word_t        pc;
    logic         rdata_done;
    logic         fault;
    logic         pred_valid;
    logic         ibus_busy;

    // Only clean completed words feed the predictor
    assign pred_valid = rdata_done && !fault;

    // Misaligned fetches are off the bus, so busy does not apply to them
    assign ibus_busy = ibus_rsp.busy && !fault;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch_stage (
        .CLK        (CLK),
        .nRST       (nRST),
        .ibus_req   (ibus_req),
        .ibus_rsp   (ibus_rsp),
        .predict    (predict),
        .ctrl       (ctrl),
        .pc         (pc),
        .rdata_done (rdata_done),
        .fault      (fault),
        .fetch_ex   (fetch_ex)
    );

    branch_predictor i_branch_predictor (
        .pc          (pc),
        .instr       (ibus_rsp.rdata),
        .instr_valid (pred_valid),
        .predict     (predict)
    );

    hazard_unit #(
        .RESET_PC (RESET_PC)
    ) i_hazard_unit (
        .CLK        (CLK),
        .nRST       (nRST),
        .redirect   (redirect),
        .ex_stall   (ex_stall),
        .ibus_busy  (ibus_busy),
        .rdata_done (rdata_done),
        .ctrl       (ctrl)
    );

endmodule

/* tb/tb_imem.sv */
/*
 * Behavioral instruction memory for the fetch testbench
 * 256 words, wait states of 0 to 3 cycles per request
 * Bus error region given by a low and high address
 */

`timescale 1ns/1ps

module tb_imem import fetch_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  ibus_req_t  ibus_req,
    input  logic [1:0] wait_pick,
    output ibus_rsp_t  ibus_rsp
);

    // Image and error region, loaded by the testbench before each test
    word_t      mem [256];
    word_t      err_lo;
    word_t      err_hi;

    logic       tracking;
    word_t      last_addr;
    logic [1:0] remaining;
    logic       new_req;
    logic [1:0] cur_wait;

    // New request when ren rises or the address moves
    assign new_req  = ibus_req.ren && (!tracking || ibus_req.addr != last_addr);
    assign cur_wait = new_req ? wait_pick : remaining;

    always_comb begin
        ibus_rsp.busy  = ibus_req.ren && (cur_wait != 2'd0);
        ibus_rsp.rdata = mem[ibus_req.addr[9:2]];
        ibus_rsp.error = (ibus_req.addr >= err_lo) && (ibus_req.addr < err_hi);
    end

    // Count down the wait, then stay ready while ren is held
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tracking  <= 1'b0;
            last_addr <= '0;
            remaining <= 2'd0;
        end else begin
            tracking  <= ibus_req.ren;
            last_addr <= ibus_req.addr;
            remaining <= (cur_wait != 2'd0) ? cur_wait - 2'd1 : 2'd0;
        end
    end

endmodule

/* tb/tb_fetch.sv */
/*
 * Testbench for the instruction fetch subsystem
 * Clock, reset, stimulus table and reference model of the fetch sequence
 * Compare tasks for words and flags, per test report and closing counts
 */

`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

    localparam word_t RESET_PC  = 32'h0000_1000;
    localparam int    NUM_TESTS = 8;
    localparam int    TIMEOUT   = 500;

    // One row of the stimulus table
    typedef struct packed {
        word_t       target;
        logic [3:0]  redir_after;
        logic [1:0]  redir_mode;
        logic        stall_on;
        logic [5:0]  count;
        word_t       err_lo;
        word_t       err_hi;
        word_t       br0_addr;
        logic [12:0] br0_imm;
        word_t       br1_addr;
        logic [12:0] br1_imm;
    } test_t;

    logic       CLK;
    logic       nRST;
    ibus_req_t  ibus_req;
    ibus_rsp_t  ibus_rsp;
    redirect_t  redirect;
    logic       ex_stall;
    fetch_ex_t  fetch_ex;
    logic [1:0] wait_pick;

    test_t      tests [NUM_TESTS];
    string      names [NUM_TESTS];
    string      cur_name;
    logic [31:0] lfsr;
    int         errors;
    int         passed;
    int         failed;

    fetch_top #(
        .RESET_PC (RESET_PC)
    ) i_fetch_top (
        .CLK      (CLK),
        .nRST     (nRST),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .redirect (redirect),
        .ex_stall (ex_stall),
        .fetch_ex (fetch_ex)
    );

    tb_imem i_tb_imem (
        .CLK       (CLK),
        .nRST      (nRST),
        .ibus_req  (ibus_req),
        .wait_pick (wait_pick),
        .ibus_rsp  (ibus_rsp)
    );

    always #4 CLK = ~CLK;

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return val;
    endfunction

    // BEQ x0, x0 with the given B-type offset
    function automatic word_t enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [12:0] imm_at(input test_t t, input word_t a);
        if (t.br0_imm != 13'd0 && a == t.br0_addr) begin
            return t.br0_imm;
        end
        if (t.br1_imm != 13'd0 && a == t.br1_addr) begin
            return t.br1_imm;
        end
        return 13'd0;
    endfunction

    // Branch where the table puts one, else an ADDI-type word from the full address
    function automatic word_t word_at(input test_t t, input word_t a);
        if (imm_at(t, a) != 13'd0) begin
            return enc_branch(imm_at(t, a));
        end
        return {a[31:7] ^ a[24:0], 7'b001_0011};
    endfunction

    // Expected entry for a fetch at pc, then pc moves to its successor
    task automatic model_step(input test_t t, inout word_t pc, output fetch_ex_t e);
        logic [12:0] imm;
        logic        mal;
        logic        err;
        mal          = (pc[1:0] != 2'b00);
        err          = !mal && pc >= t.err_lo && pc < t.err_hi;
        imm          = imm_at(t, pc);
        e            = '0;
        e.valid      = 1'b1;
        e.instr      = (mal || err) ? '0 : word_at(t, pc);
        e.pc         = pc;
        e.pc4        = pc + 32'd4;
        e.mal_insn   = mal;
        e.fault_insn = err;
        e.badaddr    = pc;
        // Only clean backward branches are predicted
        e.prediction = !mal && !err && imm[12];
        pc = e.prediction ? pc + {{19{imm[12]}}, imm} : pc + 32'd4;
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %08h, actual %08h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flags(input string what, input fetch_ex_t exp, input fetch_ex_t act);
        logic [3:0] fe;
        logic [3:0] fa;
        fe = {exp.valid, exp.prediction, exp.mal_insn, exp.fault_insn};
        fa = {act.valid, act.prediction, act.mal_insn, act.fault_insn};
        if (fa !== fe) begin
            $display("[ERROR] %s %s: expected valid/pred/mal/fault %b, actual %b",
                     cur_name, what, fe, fa);
            errors++;
        end
    endtask

    // Reset for 4 cycles, memory loaded meanwhile
    task automatic reset_and_load(input test_t t);
        nRST     = 1'b0;
        ex_stall = 1'b0;
        redirect = '0;
        for (int k = 0; k < 256; k++) begin
            i_tb_imem.mem[k] = word_at(t, RESET_PC + 32'(k) * 32'd4);
        end
        i_tb_imem.err_lo = t.err_lo;
        i_tb_imem.err_hi = t.err_hi;
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
    endtask

    task automatic run_test(input int idx);
        test_t      t;
        fetch_ex_t  exp_e;
        fetch_ex_t  hold_e;
        word_t      mpc;
        logic [7:0] r;
        logic       held;
        logic       busy_now;
        logic       pulsed;
        int         got;
        int         cycles;
        int         errs0;
        int         stall_left;
        t          = tests[idx];
        cur_name   = names[idx];
        errs0      = errors;
        mpc        = RESET_PC;
        hold_e     = '0;
        pulsed     = 1'b0;
        got        = 0;
        cycles     = 0;
        stall_left = 0;
        reset_and_load(t);
        while (got < int'(t.count) && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            held     = ex_stall;
            // First wait cycle of a new read still follows the next wait_pick
            busy_now = ibus_req.ren && ibus_rsp.busy && !i_tb_imem.new_req;
            if (held) begin
                // Stalled edge, register must keep the last expected content
                check_word("hold pc", hold_e.pc, fetch_ex.pc);
                check_word("hold instr", hold_e.instr, fetch_ex.instr);
                check_flags("hold", hold_e, fetch_ex);
            end else if (fetch_ex.valid) begin
                model_step(t, mpc, exp_e);
                check_word("pc", exp_e.pc, fetch_ex.pc);
                check_word("instr", exp_e.instr, fetch_ex.instr);
                check_word("pc4", exp_e.pc4, fetch_ex.pc4);
                check_flags("flags", exp_e, fetch_ex);
                if (exp_e.mal_insn || exp_e.fault_insn) begin
                    check_word("badaddr", exp_e.badaddr, fetch_ex.badaddr);
                end
                hold_e = exp_e;
                got++;
                cycles = 0;
            end else begin
                // Bubble loaded, register cleared
                hold_e = '0;
            end
            redirect.valid = 1'b0;
            // Mode 1 pulses at once, mode 2 waits for a read in its wait state
            if (!pulsed && t.redir_mode != 2'd0 && got >= int'(t.redir_after) &&
                (t.redir_mode == 2'd1 || busy_now)) begin
                redirect.valid  = 1'b1;
                redirect.target = t.target;
                mpc             = t.target;
                pulsed          = 1'b1;
            end
            if (t.stall_on && stall_left == 0) begin
                r = rand_bits(1);
                if (r[0]) begin
                    r          = rand_bits(2);
                    stall_left = int'(r[1:0]) + 1;
                end
            end
            ex_stall = (stall_left != 0);
            if (stall_left != 0) begin
                stall_left--;
            end
            r         = rand_bits(2);
            wait_pick = r[1:0];
        end
        if (got < int'(t.count)) begin
            $display("%s: no valid fetch entry within %0d cycles", cur_name, TIMEOUT);
            errors++;
        end
        if (t.redir_mode != 2'd0 && !pulsed) begin
            $display("%s: redirect was never injected", cur_name);
            errors++;
        end
        if (errors == errs0) begin
            passed++;
            $display("%s: ok, %0d entries", cur_name, got);
        end else begin
            failed++;
            $display("%s: FAILED, %0d of %0d entries", cur_name, got, int'(t.count));
        end
    endtask

    task automatic build_table();
        // target, after, mode, stall, count, err_lo, err_hi, br0, imm0, br1, imm1
        names[0] = "straight";
        tests[0] = '{32'h0, 4'd0, 2'd0, 1'b0, 6'd8, 32'h0, 32'h0,
                     32'h0, 13'h0, 32'h0, 13'h0};
        names[1] = "branches";
        tests[1] = '{32'h0, 4'd0, 2'd0, 1'b0, 6'd10, 32'h0, 32'h0,
                     32'h1008, 13'h0008, 32'h1010, 13'h1FF4};
        names[2] = "redirect";
        tests[2] = '{32'h1100, 4'd3, 2'd1, 1'b0, 6'd8, 32'h0, 32'h0,
                     32'h0, 13'h0, 32'h0, 13'h0};
        names[3] = "redirect_busy";
        tests[3] = '{32'h1200, 4'd2, 2'd2, 1'b0, 6'd8, 32'h0, 32'h0,
                     32'h0, 13'h0, 32'h0, 13'h0};
        names[4] = "misaligned";
        tests[4] = '{32'h1002, 4'd2, 2'd1, 1'b0, 6'd5, 32'h0, 32'h0,
                     32'h0, 13'h0, 32'h0, 13'h0};
        names[5] = "bus_error";
        tests[5] = '{32'h0, 4'd0, 2'd0, 1'b0, 6'd6, 32'h1008, 32'h1010,
                     32'h100C, 13'h1FF8, 32'h0, 13'h0};
        names[6] = "stall";
        tests[6] = '{32'h0, 4'd0, 2'd0, 1'b1, 6'd12, 32'h0, 32'h0,
                     32'h1014, 13'h1FF0, 32'h0, 13'h0};
        names[7] = "redirect_stall";
        tests[7] = '{32'h1180, 4'd3, 2'd1, 1'b1, 6'd8, 32'h0, 32'h0,
                     32'h0, 13'h0, 32'h0, 13'h0};
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        ex_stall  = 1'b0;
        redirect  = '0;
        wait_pick = 2'd0;
        lfsr      = 32'h3aec_d08a;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        build_table();
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("%0d tests passed, %0d failed, %0d check errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/fetch_pkg.sv
hw/branch_predictor.sv
hw/hazard_unit.sv
hw/fetch_stage.sv
hw/fetch_top.sv
tb/tb_imem.sv
tb/tb_fetch.sv

/* Makefile */
# Verilator lint and simulation of the instruction fetch subsystem

VERILATOR  ?= verilator
TOP        := tb_fetch
RTL_TOP    := fetch_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
